//--- sim.f
verilog/bp_pkg.sv
verilog/bp_table_if.sv
verilog/counter_ram.sv
verilog/counter_table.sv
verilog/update_engine.sv
verilog/bp_csr.sv
verilog/branch_predictor.sv
test/bp_sva.sv
test/tb_branch_predictor.sv

//--- Makefile
# Verilator simulation of the branch predictor testbench.
TOP := tb_branch_predictor

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f sim.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

//--- test/tb_branch_predictor.sv
// Testbench for the branch predictor. Applies a table of register writes, clears,
// updates, bursts and lookups, and checks the DUT against a reference counter model.
`timescale 1ns/1ps
`default_nettype none

module tb_branch_predictor;
   import bp_pkg::*;

   typedef enum logic [2:0] {
      OP_CFG_WR, OP_CLEAR, OP_UPDATE, OP_LOOKUP, OP_CHECK_ALL, OP_BURST
   } op_e;

   typedef struct packed {
      op_e        op;
      logic [4:0] idx;                                    // Index, register or burst length.
      logic       taken;
      logic [7:0] data;
      logic [7:0] exp_val;
   } row_t;

   logic       clk = 1'b0;
   logic       rst_i;
   logic       lookup_valid_i;
   logic [4:0] lookup_idx_i;
   logic       pred_valid_o;
   logic       pred_taken_o;
   logic       upd_valid_i;
   logic [4:0] upd_idx_i;
   logic       upd_taken_i;
   logic       upd_credit_o;
   logic       cfg_we_i;
   logic [1:0] cfg_addr_i;
   logic [7:0] cfg_wdata_i;
   logic [7:0] cfg_rdata_o;

   row_t       rows[$];
   logic [1:0] model [TABLE_DEPTH];                       // Expected counter per entry.
   bp_mode_e   model_mode;
   logic [1:0] model_init;
   int         credits;                                   // Credits held by the sender.
   logic       credit_pend;
   int         pulses;
   int         errors;
   int         row_errors;
   int         failed_tests;
   int         cycles;
   int         limit;
   integer     seed;

   branch_predictor dut_i (.*);

   always #5 clk = ~clk;

   // Watchdog sized from the table length.
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (limit > 0 && cycles >= limit) begin
         $display("Timeout, the run did not finish within %0d cycles", limit);
         $display("test failed");
         $finish;
      end
   end

   function automatic logic [1:0] train_counter(input logic [1:0] ctr, input logic taken);
      int v;
      v = int'(ctr) + (taken ? 1 : -1);
      v = (v < 0) ? 0 : ((v > 3) ? 3 : v);                // Saturate at both ends.
      return v[1:0];
   endfunction

   function automatic bp_mode_e legal_mode(input logic [7:0] data);
      if (data == 8'd0) return MODE_STATIC_NT;
      if (data == 8'd1) return MODE_STATIC_T;
      return MODE_DYNAMIC;                                // Anything else means dynamic.
   endfunction

   function automatic logic model_pred(input logic [4:0] idx);
      if (model_mode == MODE_STATIC_NT) return 1'b0;
      if (model_mode == MODE_STATIC_T) return 1'b1;
      return model[idx][1];
   endfunction

   task automatic add_row(input op_e op, input logic [4:0] idx, input logic taken,
                          input logic [7:0] data, input logic [7:0] exp_val);
      rows.push_back('{op, idx, taken, data, exp_val});
   endtask

   task automatic report_mismatch(input string name, input logic [7:0] got,
                                  input logic [7:0] want);
      errors++;
      row_errors++;
      $display("FAILED %s got %h expected %h", name, got, want);
   endtask

   task automatic report_text(input string msg);
      errors++;
      row_errors++;
      $display("%s", msg);
   endtask

   // A returned credit becomes usable one cycle after its pulse.
   task automatic tick();
      @(negedge clk);
      if (credit_pend === 1'b1) credits++;
      credit_pend = upd_credit_o;
      if (upd_credit_o === 1'b1) pulses++;
   endtask

   task automatic settle();
      tick();
      while (credits != UPD_DEPTH || cfg_rdata_o[0] !== 1'b0) tick();
   endtask

   task automatic send_update(input logic [4:0] idx, input logic taken);
      while (credits == 0) tick();
      upd_valid_i = 1'b1;
      upd_idx_i   = idx;
      upd_taken_i = taken;
      credits--;
      model[idx] = train_counter(model[idx], taken);
      tick();
      upd_valid_i = 1'b0;
   endtask

   task automatic write_cfg(input logic [1:0] addr, input logic [7:0] data,
                            input logic [7:0] exp_val);
      cfg_we_i    = 1'b1;
      cfg_addr_i  = addr;
      cfg_wdata_i = data;
      tick();
      if (cfg_rdata_o !== exp_val) report_mismatch("cfg_rdata_o", cfg_rdata_o, exp_val);
      cfg_we_i   = 1'b0;
      cfg_addr_i = CSR_STATUS;                            // Status is polled while idle.
      if (addr == CSR_MODE) model_mode = legal_mode(data);
      if (addr == CSR_INIT) model_init = data[1:0];
   endtask

   task automatic run_clear();
      int waited;
      settle();
      cfg_we_i    = 1'b1;
      cfg_addr_i  = CSR_CLEAR;
      cfg_wdata_i = 8'h01;
      tick();
      cfg_we_i   = 1'b0;
      cfg_addr_i = CSR_STATUS;
      tick();
      waited = 2;
      if (cfg_rdata_o[0] !== 1'b1) report_text("Busy did not rise after the clear write");
      while (cfg_rdata_o[0] === 1'b1 && waited < 40) begin
         tick();
         waited++;
      end
      if (waited > 34 || cfg_rdata_o[0] !== 1'b0) begin
         report_text("Busy did not fall within 34 cycles of the clear write");
      end
      for (int i = 0; i < TABLE_DEPTH; i++) model[i] = model_init;
   endtask

   task automatic lookup_one(input logic [4:0] idx, input logic want);
      settle();
      lookup_valid_i = 1'b1;
      lookup_idx_i   = idx;
      tick();
      lookup_valid_i = 1'b0;
      if (pred_valid_o !== 1'b1) report_mismatch("pred_valid_o", {7'd0, pred_valid_o}, 8'h01);
      if (pred_taken_o !== want) begin
         report_mismatch("pred_taken_o", {7'd0, pred_taken_o}, {7'd0, want});
      end
   endtask

   // Sweeps every entry with one lookup per cycle and checks each result a cycle later.
   task automatic check_all();
      logic want;
      settle();
      for (int i = 0; i <= TABLE_DEPTH; i++) begin
         if (i > 0) begin
            want = model_pred(5'(i - 1));
            if (pred_valid_o !== 1'b1) begin
               report_mismatch("pred_valid_o", {7'd0, pred_valid_o}, 8'h01);
            end
            if (pred_taken_o !== want) begin
               report_mismatch("pred_taken_o", {7'd0, pred_taken_o}, {7'd0, want});
            end
         end
         lookup_valid_i = (i < TABLE_DEPTH);
         lookup_idx_i   = 5'(i);
         tick();
      end
      lookup_valid_i = 1'b0;
   endtask

   task automatic run_burst(input int n);
      int         start;
      logic [31:0] rnd;
      start = pulses;
      for (int k = 0; k < n; k++) begin
         rnd = $random(seed);
         send_update(rnd[4:0], rnd[8]);
      end
      settle();
      if (pulses - start != n) report_mismatch("upd_credit_o", 8'(pulses - start), 8'(n));
   endtask

   initial begin
      row_t row;
      add_row(OP_CFG_WR, 5'(CSR_INIT), 0, 8'd1, 8'd1);
      add_row(OP_CLEAR, 0, 0, 0, 0);
      add_row(OP_CHECK_ALL, 0, 0, 0, 0);
      add_row(OP_LOOKUP, 5, 0, 0, 8'd0);
      add_row(OP_CFG_WR, 5'(CSR_INIT), 0, 8'd2, 8'd2);
      add_row(OP_CLEAR, 0, 0, 0, 0);
      add_row(OP_CHECK_ALL, 0, 0, 0, 0);
      add_row(OP_LOOKUP, 17, 0, 0, 8'd1);
      add_row(OP_CFG_WR, 5'(CSR_INIT), 0, 8'd0, 8'd0);    // Saturation starts from STRONG_NT.
      add_row(OP_CLEAR, 0, 0, 0, 0);
      add_row(OP_UPDATE, 9, 1, 0, 0);
      add_row(OP_LOOKUP, 9, 0, 0, 8'd0);
      add_row(OP_UPDATE, 9, 1, 0, 0);
      add_row(OP_LOOKUP, 9, 0, 0, 8'd1);
      add_row(OP_UPDATE, 9, 1, 0, 0);
      add_row(OP_UPDATE, 9, 1, 0, 0);
      add_row(OP_LOOKUP, 9, 0, 0, 8'd1);
      add_row(OP_UPDATE, 9, 0, 0, 0);
      add_row(OP_LOOKUP, 9, 0, 0, 8'd1);
      add_row(OP_CFG_WR, 5'(CSR_MODE), 0, 8'd1, 8'd1);
      add_row(OP_LOOKUP, 3, 0, 0, 8'd1);
      add_row(OP_UPDATE, 3, 1, 0, 0);
      add_row(OP_UPDATE, 3, 1, 0, 0);
      add_row(OP_CFG_WR, 5'(CSR_MODE), 0, 8'd0, 8'd0);
      add_row(OP_LOOKUP, 3, 0, 0, 8'd0);
      add_row(OP_LOOKUP, 9, 0, 0, 8'd0);
      add_row(OP_CFG_WR, 5'(CSR_MODE), 0, 8'd2, 8'd2);
      add_row(OP_LOOKUP, 3, 0, 0, 8'd1);
      add_row(OP_LOOKUP, 9, 0, 0, 8'd1);
      add_row(OP_CFG_WR, 5'(CSR_MODE), 0, 8'd3, 8'd2);
      add_row(OP_CFG_WR, 5'(CSR_MODE), 0, 8'h55, 8'd2);
      add_row(OP_BURST, 4, 0, 0, 0);
      add_row(OP_BURST, 12, 0, 0, 0);
      add_row(OP_CHECK_ALL, 0, 0, 0, 0);
      add_row(OP_CFG_WR, 5'(CSR_INIT), 0, 8'd3, 8'd3);
      add_row(OP_CLEAR, 0, 0, 0, 0);
      add_row(OP_CHECK_ALL, 0, 0, 0, 0);
      add_row(OP_BURST, 4, 0, 0, 0);
      add_row(OP_CHECK_ALL, 0, 0, 0, 0);

      limit          = rows.size() * 40 + 200;
      seed           = 32'h194d798d;
      rst_i          = 1'b1;
      lookup_valid_i = 1'b0;
      lookup_idx_i   = '0;
      upd_valid_i    = 1'b0;
      upd_idx_i      = '0;
      upd_taken_i    = 1'b0;
      cfg_we_i       = 1'b0;
      cfg_addr_i     = CSR_STATUS;
      cfg_wdata_i    = '0;
      model_mode     = MODE_DYNAMIC;
      model_init     = WEAK_NT;
      credits        = UPD_DEPTH;
      credit_pend    = 1'b0;
      pulses         = 0;
      errors         = 0;
      failed_tests   = 0;
      repeat (8) tick();
      rst_i = 1'b0;

      foreach (rows[n]) begin
         row = rows[n];
         row_errors = 0;
         case (row.op)
            OP_CFG_WR:    write_cfg(row.idx[1:0], row.data, row.exp_val);
            OP_CLEAR:     run_clear();
            OP_UPDATE:    send_update(row.idx, row.taken);
            OP_LOOKUP:    lookup_one(row.idx, row.exp_val[0]);
            OP_CHECK_ALL: check_all();
            default:      run_burst(int'(row.idx));
         endcase
         if (row_errors != 0) failed_tests++;
         $display("Test %0d %s %s", n, row.op.name(), (row_errors == 0) ? "ok" : "had errors");
      end

      $display("%0d tests, %0d failed, %0d errors", rows.size(), failed_tests, errors);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- test/bp_sva.sv
// Protocol checker for the branch predictor, bound to the top level.
// Covers lookup latency, credit accounting, clear sweep length and credit pulse spacing.
`timescale 1ns/1ps
`default_nettype none

module bp_sva (
   input logic clk,
   input logic rst_i,
   input logic lookup_valid_i,
   input logic pred_valid_i,
   input logic upd_valid_i,
   input logic upd_credit_i,
   input logic busy_i
);
   import bp_pkg::*;

   logic [3:0] outstanding;                               // Updates sent but not yet retired.
   logic [5:0] busy_len;                                  // Length of the current busy run.

   always_ff @(posedge clk) begin
      if (rst_i) begin
         outstanding <= '0;
         busy_len    <= '0;
      end else begin
         outstanding <= outstanding + 4'(upd_valid_i) - 4'(upd_credit_i);
         busy_len    <= busy_i ? busy_len + 6'd1 : 6'd0;
      end
   end

   pred_follows_lookup: assert property (@(posedge clk) disable iff (rst_i)
      pred_valid_i == $past(lookup_valid_i))
      else $error("Prediction valid does not follow the lookup by one cycle");

   credits_bounded: assert property (@(posedge clk) disable iff (rst_i)
      outstanding <= 4'(UPD_DEPTH))
      else $error("More updates outstanding than there are credits");

   busy_not_too_long: assert property (@(posedge clk) disable iff (rst_i)
      busy_i |-> busy_len < 6'(TABLE_DEPTH))
      else $error("Clear sweep runs longer than the table");

   busy_full_length: assert property (@(posedge clk) disable iff (rst_i)
      $fell(busy_i) |-> busy_len == 6'(TABLE_DEPTH))
      else $error("Clear sweep ended early");

   credit_spaced: assert property (@(posedge clk) disable iff (rst_i)
      upd_credit_i |=> !upd_credit_i)
      else $error("Credit returned in two consecutive cycles");

endmodule

bind branch_predictor bp_sva sva_i (
   .clk            (clk),
   .rst_i          (rst_i),
   .lookup_valid_i (lookup_valid_i),
   .pred_valid_i   (pred_valid_o),
   .upd_valid_i    (upd_valid_i),
   .upd_credit_i   (upd_credit_o),
   .busy_i         (busy)
);

`default_nettype wire

//--- verilog/branch_predictor.sv
// Top level of the branch direction predictor. Connects the register block,
// the update engine and the counter table; all external signals are plain ports.
`timescale 1ns/1ps
`default_nettype none

module branch_predictor (
   input  logic                      clk,
   input  logic                      rst_i,
   input  logic                      lookup_valid_i,
   input  logic [bp_pkg::IDX_W-1:0]  lookup_idx_i,
   output logic                      pred_valid_o,
   output logic                      pred_taken_o,
   input  logic                      upd_valid_i,
   input  logic [bp_pkg::IDX_W-1:0]  upd_idx_i,
   input  logic                      upd_taken_i,
   output logic                      upd_credit_o,
   input  logic                      cfg_we_i,
   input  logic [1:0]                cfg_addr_i,
   input  logic [bp_pkg::CFG_DW-1:0] cfg_wdata_i,
   output logic [bp_pkg::CFG_DW-1:0] cfg_rdata_o
);
   import bp_pkg::*;

   csr_addr_e  cfg_addr;
   bp_mode_e   mode;
   ctr_state_e init;
   logic       clear;
   logic       busy;                                    // High for the whole clear sweep.

   bp_table_if tbl_if ();

   assign cfg_addr = csr_addr_e'(cfg_addr_i);

   bp_csr csr_i (
      .clk         (clk),
      .rst_i       (rst_i),
      .cfg_we_i    (cfg_we_i),
      .cfg_addr_i  (cfg_addr),
      .cfg_wdata_i (cfg_wdata_i),
      .cfg_rdata_o (cfg_rdata_o),
      .busy_i      (busy),
      .mode_o      (mode),
      .init_o      (init),
      .clear_o     (clear)
   );

   update_engine engine_i (
      .clk          (clk),
      .rst_i        (rst_i),
      .upd_valid_i  (upd_valid_i),
      .upd_idx_i    (upd_idx_i),
      .upd_taken_i  (upd_taken_i),
      .upd_credit_o (upd_credit_o),
      .clear_i      (clear),
      .init_i       (init),
      .busy_o       (busy),
      .tbl          (tbl_if.engine)
   );

   counter_table table_i (
      .clk            (clk),
      .lookup_valid_i (lookup_valid_i),
      .lookup_idx_i   (lookup_idx_i),
      .mode_i         (mode),
      .pred_valid_o   (pred_valid_o),
      .pred_taken_o   (pred_taken_o),
      .tbl            (tbl_if.store)
   );

endmodule

`default_nettype wire

//--- verilog/bp_csr.sv
// Configuration registers of the predictor: prediction mode, initial counter value,
// a clear command and a busy status bit. Reads return the addressed register directly.
`timescale 1ns/1ps
`default_nettype none

module bp_csr (
   input  logic                      clk,
   input  logic                      rst_i,
   input  logic                      cfg_we_i,
   input  bp_pkg::csr_addr_e         cfg_addr_i,
   input  logic [bp_pkg::CFG_DW-1:0] cfg_wdata_i,
   output logic [bp_pkg::CFG_DW-1:0] cfg_rdata_o,
   input  logic                      busy_i,
   output bp_pkg::bp_mode_e          mode_o,
   output bp_pkg::ctr_state_e        init_o,
   output logic                      clear_o
);
   import bp_pkg::*;

   bp_mode_e wr_mode;

   // Values outside the defined modes fall back to dynamic prediction.
   always_comb begin
      if (cfg_wdata_i == CFG_DW'(MODE_STATIC_NT)) begin
         wr_mode = MODE_STATIC_NT;
      end else if (cfg_wdata_i == CFG_DW'(MODE_STATIC_T)) begin
         wr_mode = MODE_STATIC_T;
      end else begin
         wr_mode = MODE_DYNAMIC;
      end
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         mode_o <= MODE_DYNAMIC;
         init_o <= WEAK_NT;
      end else if (cfg_we_i) begin
         case (cfg_addr_i)
            CSR_MODE: mode_o <= wr_mode;
            CSR_INIT: init_o <= ctr_state_e'(cfg_wdata_i[CTR_W-1:0]);
            default:  ;
         endcase
      end
   end

   // A clear request during a sweep is dropped.
   assign clear_o = cfg_we_i && (cfg_addr_i == CSR_CLEAR) && !busy_i;

   always_comb begin
      case (cfg_addr_i)
         CSR_MODE:   cfg_rdata_o = CFG_DW'(mode_o);
         CSR_INIT:   cfg_rdata_o = CFG_DW'(init_o);
         CSR_STATUS: cfg_rdata_o = CFG_DW'(busy_i);
         default:    cfg_rdata_o = '0;                    // The clear register reads as zero.
      endcase
   end

endmodule

`default_nettype wire

//--- verilog/update_engine.sv
// Update path of the predictor. Buffers branch outcomes under credit flow control,
// trains counters by read-modify-write and runs the clear sweep over the table.
`timescale 1ns/1ps
`default_nettype none

module update_engine (
   input  logic                     clk,
   input  logic                     rst_i,
   input  logic                     upd_valid_i,
   input  logic [bp_pkg::IDX_W-1:0] upd_idx_i,
   input  logic                     upd_taken_i,
   output logic                     upd_credit_o,
   input  logic                     clear_i,
   input  bp_pkg::ctr_state_e       init_i,
   output logic                     busy_o,
   bp_table_if.engine               tbl
);
   import bp_pkg::*;

   typedef enum logic [1:0] {IDLE, READ, WRITE, CLEAR} eng_state_e;

   eng_state_e           state_q;
   eng_state_e           state_d;
   logic [IDX_W-1:0]     q_idx [UPD_DEPTH];
   logic                 q_taken [UPD_DEPTH];
   logic [UPD_PTR_W-1:0] wr_ptr_q;
   logic [UPD_PTR_W-1:0] rd_ptr_q;
   logic [UPD_CNT_W-1:0] count_q;
   logic                 push;
   logic                 pop;
   logic [IDX_W-1:0]     head_idx;
   logic                 head_taken;
   logic [IDX_W-1:0]     clr_idx_q;
   ctr_state_e           clr_val_q;

   // Saturating step toward the observed outcome.
   function automatic ctr_state_e ctr_next(input ctr_state_e cur, input logic taken);
      ctr_state_e nxt;
      nxt = cur;
      if (taken && (cur != STRONG_T)) begin
         nxt = ctr_state_e'(cur + 2'd1);
      end else if (!taken && (cur != STRONG_NT)) begin
         nxt = ctr_state_e'(cur - 2'd1);
      end
      return nxt;
   endfunction

   assign push = upd_valid_i && (count_q != UPD_CNT_W'(UPD_DEPTH)); // Credits keep this true.
   assign pop  = (state_q == WRITE);                    // Head retires with its write.

   assign head_idx   = q_idx[rd_ptr_q];
   assign head_taken = q_taken[rd_ptr_q];

   always_ff @(posedge clk) begin
      if (push) begin
         q_idx[wr_ptr_q]   <= upd_idx_i;
         q_taken[wr_ptr_q] <= upd_taken_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push) begin
            wr_ptr_q <= wr_ptr_q + UPD_PTR_W'(1);
         end
         if (pop) begin
            rd_ptr_q <= rd_ptr_q + UPD_PTR_W'(1);
         end
         count_q <= count_q + UPD_CNT_W'(push) - UPD_CNT_W'(pop);
      end
   end

   // A clear abandons a pending read but lets a write in flight land first.
   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            if (clear_i) state_d = CLEAR;
            else if (count_q != '0) state_d = READ;
         end
         READ: state_d = clear_i ? CLEAR : WRITE;
         WRITE: begin
            if (clear_i) state_d = CLEAR;
            else if ((count_q > UPD_CNT_W'(1)) || push) state_d = READ;
            else state_d = IDLE;
         end
         CLEAR: begin
            if (clr_idx_q == IDX_W'(TABLE_DEPTH - 1)) begin
               state_d = (count_q != '0) ? READ : IDLE;
            end
         end
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         state_q   <= IDLE;
         clr_idx_q <= '0;
      end else begin
         state_q <= state_d;
         if (state_q == CLEAR) begin
            clr_idx_q <= clr_idx_q + IDX_W'(1);         // Wraps back to 0 after the last entry.
         end
      end
   end

   always_ff @(posedge clk) begin
      if (clear_i && (state_q != CLEAR)) begin
         clr_val_q <= init_i;                           // Sweep value is fixed at the start.
      end
   end

   always_comb begin
      tbl.en    = (state_q != IDLE);
      tbl.we    = (state_q == WRITE) || (state_q == CLEAR);
      tbl.addr  = (state_q == CLEAR) ? clr_idx_q : head_idx;
      tbl.wdata = (state_q == CLEAR) ? clr_val_q : ctr_next(tbl.rdata, head_taken);
   end

   assign upd_credit_o = pop;
   assign busy_o       = (state_q == CLEAR);

endmodule

`default_nettype wire

//--- verilog/counter_table.sv
// Counter table around the two-port RAM.
// Lookups use port 0 and get a prediction one cycle later; port 1 follows the update port.
`timescale 1ns/1ps
`default_nettype none

module counter_table (
   input  logic                     clk,
   input  logic                     lookup_valid_i,
   input  logic [bp_pkg::IDX_W-1:0] lookup_idx_i,
   input  bp_pkg::bp_mode_e         mode_i,
   output logic                     pred_valid_o,
   output logic                     pred_taken_o,
   bp_table_if.store                tbl
);
   import bp_pkg::*;

   logic [CTR_W-1:0] lookup_ctr;
   logic [CTR_W-1:0] upd_rdata;
   logic             upd_we;

   // Write enable only counts while the port is selected.
   assign upd_we = tbl.en && tbl.we;

   counter_ram ram_i (
      .clk      (clk),
      .en0_i    (lookup_valid_i),
      .addr0_i  (lookup_idx_i),
      .rdata0_o (lookup_ctr),
      .en1_i    (tbl.en),
      .we1_i    (upd_we),
      .addr1_i  (tbl.addr),
      .wdata1_i (tbl.wdata),
      .rdata1_o (upd_rdata)
   );

   assign tbl.rdata = ctr_state_e'(upd_rdata);

   always_ff @(posedge clk) begin
      pred_valid_o <= lookup_valid_i;                     // Read data is ready one cycle later.
   end

   // Static modes override the counter; training continues underneath.
   always_comb begin
      case (mode_i)
         MODE_STATIC_NT: pred_taken_o = 1'b0;
         MODE_STATIC_T:  pred_taken_o = 1'b1;
         default:        pred_taken_o = lookup_ctr[CTR_W-1];
      endcase
   end

endmodule

`default_nettype wire

//--- verilog/counter_ram.sv
// Behavioural two-port RAM holding the 2-bit counters.
// Port 0 only reads; port 1 reads or writes. Both ports register their read data.
`timescale 1ns/1ps
`default_nettype none

module counter_ram (
   input  logic                     clk,
   input  logic                     en0_i,
   input  logic [bp_pkg::IDX_W-1:0] addr0_i,
   output logic [bp_pkg::CTR_W-1:0] rdata0_o,
   input  logic                     en1_i,
   input  logic                     we1_i,
   input  logic [bp_pkg::IDX_W-1:0] addr1_i,
   input  logic [bp_pkg::CTR_W-1:0] wdata1_i,
   output logic [bp_pkg::CTR_W-1:0] rdata1_o
);
   import bp_pkg::*;

   logic [CTR_W-1:0] mem [TABLE_DEPTH];

   // Lookup port. Sampling before the write lands gives the old value on a collision.
   always_ff @(posedge clk) begin
      if (en0_i) begin
         rdata0_o <= mem[addr0_i];
      end
   end

   always_ff @(posedge clk) begin
      if (en1_i && we1_i) begin
         mem[addr1_i] <= wdata1_i;                        // Update or clear write.
      end
   end

   always_ff @(posedge clk) begin
      if (en1_i) begin
         rdata1_o <= mem[addr1_i];                        // Read first on this port too.
      end
   end

endmodule

`default_nettype wire

//--- verilog/bp_table_if.sv
// Update port of the counter table.
// The update engine drives the request side and the table returns read data.
`timescale 1ns/1ps
`default_nettype none

interface bp_table_if;
   import bp_pkg::*;

   logic             en;                                  // Port access this cycle.
   logic             we;                                  // Write when set, read otherwise.
   logic [IDX_W-1:0] addr;                                // Counter index.
   ctr_state_e       wdata;                               // New counter value.
   ctr_state_e       rdata;                               // Registered read data.

   modport engine (
      output en,
      output we,
      output addr,
      output wdata,
      input  rdata
   );

   // Table side of the port.
   modport store (
      input  en,
      input  we,
      input  addr,
      input  wdata,
      output rdata
   );

endinterface

`default_nettype wire

//--- verilog/bp_pkg.sv
// Shared sizes and encodings for the branch direction predictor.
// Modules import this package inside their bodies and use scoped names in port lists.
`default_nettype none

package bp_pkg;

   localparam int TABLE_DEPTH = 32;                       // Counters in the table.
   localparam int IDX_W       = $clog2(TABLE_DEPTH);      // Index bits taken from the PC.
   localparam int CTR_W       = 2;                        // Bits per saturating counter.

   localparam int UPD_DEPTH   = 4;                        // Update credits and queue slots.
   localparam int UPD_PTR_W   = $clog2(UPD_DEPTH);        // Queue pointer width.
   localparam int UPD_CNT_W   = $clog2(UPD_DEPTH + 1);    // Queue fill level width.

   localparam int CFG_DW      = 8;                        // Register data width.

   // Two-bit counter. The high bit is the taken prediction.
   typedef enum logic [CTR_W-1:0] {
      STRONG_NT = 2'd0,
      WEAK_NT   = 2'd1,
      WEAK_T    = 2'd2,
      STRONG_T  = 2'd3
   } ctr_state_e;

   // Prediction mode selected through the register block.
   typedef enum logic [1:0] {
      MODE_STATIC_NT = 2'd0,                              // Always predict not taken.
      MODE_STATIC_T  = 2'd1,                              // Always predict taken.
      MODE_DYNAMIC   = 2'd2                               // Use the counter value.
   } bp_mode_e;

   // Register map.
   typedef enum logic [1:0] {
      CSR_MODE   = 2'd0,                                  // Read and write.
      CSR_INIT   = 2'd1,                                  // Read and write.
      CSR_CLEAR  = 2'd2,                                  // Any write starts a sweep.
      CSR_STATUS = 2'd3                                   // Read only, bit 0 is busy.
   } csr_addr_e;

endpackage

`default_nettype wire
